// File: decode_issue.f
src/decode_pkg.sv
src/instr_classifier.sv
src/issue_control.sv
src/alu_operand_prep.sv
src/ls_branch_operand_prep.sv
src/decode_issue.sv
tests/decode_issue_checker.sv
tests/decode_issue_tb.sv

// File: Bender.yml
package:
  name: decode_issue

sources:
  - files:
      - src/decode_pkg.sv
      - src/instr_classifier.sv
      - src/issue_control.sv
      - src/alu_operand_prep.sv
      - src/ls_branch_operand_prep.sv
      - src/decode_issue.sv
  - target: test
    files:
      - tests/decode_issue_checker.sv
      - tests/decode_issue_tb.sv

// File: tests/decode_issue_tb.sv
`timescale 1ns/1ps

module decode_issue_tb;
    import decode_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;

    // Full 7-bit RV32I opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_ARITH  = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;

    logic          clk = 1'b0;
    logic          rst;
    logic          instr_valid, rs1_conflict, rs2_conflict, flush;
    logic          alu_ready, ls_ready, branch_ready;
    word_t         instruction, pc, rs1_data, rs2_data;
    logic          instr_pop, illegal_instruction, rd_issued;
    reg_addr_t     rs1_addr, rs2_addr, rd_addr;
    unit_sel_t     issue;
    logic          alu_new_request, ls_new_request, branch_new_request;
    operand_t      alu_in1, alu_in2;
    word_t         alu_shifter_in, ls_offset;
    logic          alu_subtract, alu_arith, alu_lshift;
    alu_logic_op_t alu_logic_op;
    alu_op_t       alu_op;
    logic          ls_forward, ls_is_load, ls_is_store;
    logic          branch_use_signed, branch_jal, branch_jalr;

    int            error_count = 0;
    int            check_count = 0;
    logic [31:0]   rng_state = 32'd71091;

    decode_issue UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // I-type, also R-type with funct7 and rs2 in the immediate
    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input fn3_t f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // S-type, also B-type with the field layout kept
    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input fn3_t f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic operand_t extend33(input word_t val, input logic unsigned_op);
        return {val[31] & ~unsigned_op, val};
    endfunction

    task automatic check_value(input string name, input logic [32:0] got, input logic [32:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    //----------------------------------------------------------------------
    // Bus drivers
    //----------------------------------------------------------------------
    task automatic present(input word_t instr, input word_t rs1_val, input word_t rs2_val,
                           input logic c1, input logic c2, input logic [2:0] ready,
                           input logic fl);
        @(posedge clk);
        #1;
        instruction  = instr;
        instr_valid  = 1'b1;
        pc           = next_random() & ~32'h3;
        rs1_data     = rs1_val;
        rs2_data     = rs2_val;
        rs1_conflict = c1;
        rs2_conflict = c2;
        {branch_ready, ls_ready, alu_ready} = ready;
        flush        = fl;
        @(negedge clk); // Combinational outputs settled
    endtask

    task automatic present_clean(input word_t instr);
        present(instr, next_random(), next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
    endtask

    task automatic release_bus();
        @(posedge clk);
        #1;
        instr_valid  = 1'b0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        flush        = 1'b0;
        {branch_ready, ls_ready, alu_ready} = 3'b111;
        @(negedge clk); // Registered outputs of the last issue visible
    endtask

    task automatic issue_one(input word_t instr, input unit_sel_t exp_unit, input logic exp_rd);
        present_clean(instr);
        check_value("issue", issue, exp_unit);
        check_value("instr_pop", instr_pop, 1'b1);
        check_value("rd_issued", rd_issued, exp_rd);
        release_bus();
        check_value("new_request", {branch_new_request, ls_new_request, alu_new_request},
                    exp_unit);
    endtask

    task automatic expect_pop(input word_t instr, input logic c1, input logic c2,
                              input logic [2:0] ready, input logic fl, input logic exp_pop);
        present(instr, next_random(), next_random(), c1, c2, ready, fl);
        check_value("instr_pop", instr_pop, exp_pop);
        release_bus();
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic route_opcodes();
        issue_one({20'h12345, 5'd1, OP_LUI}, 3'b001, 1'b1);
        issue_one({20'h00010, 5'd2, OP_AUIPC}, 3'b001, 1'b1);
        issue_one(enc_i(12'h07f, 5'd1, 3'b000, 5'd3, OP_IMM), 3'b001, 1'b1);
        issue_one(enc_i({7'h00, 5'd2}, 5'd1, 3'b000, 5'd4, OP_ARITH), 3'b001, 1'b1);
        issue_one(enc_i(12'h004, 5'd1, 3'b010, 5'd5, OP_LOAD), 3'b010, 1'b1);
        issue_one(enc_s(12'h008, 5'd5, 5'd1, 3'b010, OP_STORE), 3'b010, 1'b0);
        issue_one(enc_s(12'h010, 5'd2, 5'd1, 3'b000, OP_BRANCH), 3'b100, 1'b0);
        issue_one({20'h00100, 5'd1, OP_JAL}, 3'b100, 1'b1);
        issue_one(enc_i(12'h000, 5'd1, 3'b000, 5'd0, OP_JALR), 3'b100, 1'b0); // rd is x0
    endtask

    task automatic reject_illegal();
        word_t bad_ops [4];
        bad_ops[0] = 32'h0000_0073;                                  // ECALL
        bad_ops[1] = enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, OP_FENCE);
        bad_ops[2] = enc_i({7'h01, 5'd2}, 5'd1, 3'b000, 5'd3, OP_ARITH); // MUL
        bad_ops[3] = enc_i(12'h001, 5'd1, 3'b000, 5'd3, 7'b0010010); // Compressed marker
        foreach (bad_ops[i]) begin
            present_clean(bad_ops[i]);
            check_value("illegal_instruction", illegal_instruction, 1'b1);
            check_value("issue", issue, 3'b000);
            check_value("instr_pop", instr_pop, 1'b0);
            release_bus();
        end
    endtask

    task automatic stall_on_hazards();
        word_t add_op  = enc_i({7'h00, 5'd2}, 5'd1, 3'b000, 5'd4, OP_ARITH);
        word_t addi_op = enc_i(12'h010, 5'd1, 3'b000, 5'd4, OP_IMM);
        expect_pop(add_op, 1'b1, 1'b0, 3'b111, 1'b0, 1'b0);
        expect_pop(add_op, 1'b0, 1'b1, 3'b111, 1'b0, 1'b0);
        expect_pop(add_op, 1'b0, 1'b0, 3'b110, 1'b0, 1'b0); // ALU busy
        expect_pop(add_op, 1'b0, 1'b0, 3'b111, 1'b1, 1'b0);
        expect_pop(addi_op, 1'b0, 1'b1, 3'b111, 1'b0, 1'b1); // rs2 unused
        expect_pop({20'h00001, 5'd3, OP_LUI}, 1'b1, 1'b0, 3'b111, 1'b0, 1'b1);
    endtask

    task automatic alu_operand_rules();
        word_t rs1_val = next_random() | 32'h8000_0000; // Negative, so bit 32 matters
        word_t reversed;
        word_t instr;
        reversed = {<<{rs1_val}};
        instr = {20'habcde, 5'd5, OP_LUI};
        present(instr, rs1_val, next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_in1", alu_in1, 33'h0);
        check_value("alu_in2", alu_in2, extend33(32'habcde000, instr[12]));
        check_value("alu_logic_op", alu_logic_op, ALU_LOGIC_ADD);
        check_value("alu_op", alu_op, ALU_ADD_SUB);
        instr = {20'h00400, 5'd6, OP_AUIPC};
        present(instr, rs1_val, next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_in1", alu_in1, extend33(pc, instr[12]));
        instr = enc_i(12'hffb, 5'd4, 3'b000, 5'd3, OP_IMM); // ADDI x3, x4, -5
        present(instr, rs1_val, next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_in1", alu_in1, extend33(rs1_val, 1'b0));
        check_value("alu_in2", alu_in2, 33'h1_ffff_fffb);
        check_value("alu_subtract", alu_subtract, 1'b0);
        present_clean(enc_i({7'h20, 5'd2}, 5'd1, 3'b000, 5'd7, OP_ARITH)); // SUB
        release_bus();
        check_value("alu_subtract", alu_subtract, 1'b1);
        instr = enc_i({7'h00, 5'd2}, 5'd1, 3'b011, 5'd7, OP_ARITH); // SLTU
        present(instr, rs1_val, rs1_val, 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_in1", alu_in1, {1'b0, rs1_val});
        check_value("alu_in2[32]", alu_in2[32], 1'b0);
        check_value("alu_subtract", alu_subtract, 1'b1);
        check_value("alu_op", alu_op, ALU_SLT);
        instr = enc_i({7'h20, 5'd2}, 5'd1, 3'b101, 5'd7, OP_ARITH); // SRA
        present(instr, rs1_val, next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_shifter_in", alu_shifter_in, rs1_val);
        check_value("alu_arith", alu_arith, 1'b1);
        check_value("alu_lshift", alu_lshift, 1'b0);
        check_value("alu_op", alu_op, ALU_RSHIFT);
        instr = enc_i({7'h00, 5'd2}, 5'd1, 3'b001, 5'd7, OP_ARITH); // SLL
        present(instr, rs1_val, next_random(), 1'b0, 1'b0, 3'b111, 1'b0);
        release_bus();
        check_value("alu_shifter_in", alu_shifter_in, reversed);
        check_value("alu_arith", alu_arith, 1'b0);
        check_value("alu_lshift", alu_lshift, 1'b1);
        check_value("alu_op", alu_op, ALU_LSHIFT);
        present_clean(enc_i(12'h0f0, 5'd1, 3'b111, 5'd7, OP_IMM)); // ANDI
        release_bus();
        check_value("alu_logic_op", alu_logic_op, ALU_LOGIC_AND);
    endtask

    task automatic load_store_forwarding();
        word_t load_x7   = enc_i(12'hff8, 5'd2, 3'b010, 5'd7, OP_LOAD);   // LW x7, -8(x2)
        word_t store_x7  = enc_s(12'h014, 5'd7, 5'd3, 3'b010, OP_STORE);  // SW x7, 20(x3)
        word_t store_neg = enc_s(12'hfdc, 5'd7, 5'd3, 3'b010, OP_STORE);  // SW x7, -36(x3)
        present_clean(load_x7);
        check_value("ls_offset", ls_offset, 32'hffff_fff8);
        check_value("ls_is_load", ls_is_load, 1'b1);
        check_value("issue", issue, 3'b010);
        check_value("rs1_addr", rs1_addr, 5'd2);
        check_value("rd_addr", rd_addr, 5'd7);
        release_bus();
        present(store_x7, next_random(), next_random(), 1'b0, 1'b1, 3'b111, 1'b0);
        check_value("instr_pop", instr_pop, 1'b1);
        check_value("ls_forward", ls_forward, 1'b1);
        check_value("ls_offset", ls_offset, 32'h0000_0014);
        check_value("ls_is_store", ls_is_store, 1'b1);
        check_value("rs1_addr", rs1_addr, 5'd3);
        check_value("rs2_addr", rs2_addr, 5'd7);
        release_bus();
        // Reload x7, then overwrite it from the ALU
        issue_one(load_x7, 3'b010, 1'b1);
        issue_one(enc_i(12'h001, 5'd0, 3'b000, 5'd7, OP_IMM), 3'b001, 1'b1);
        present(store_neg, next_random(), next_random(), 1'b0, 1'b1, 3'b111, 1'b0);
        check_value("instr_pop", instr_pop, 1'b0);
        check_value("ls_offset", ls_offset, 32'hffff_ffdc);
        release_bus();
    endtask

    task automatic expect_branch(input word_t instr, input logic exp_signed,
                                 input logic exp_jal, input logic exp_jalr);
        present_clean(instr);
        check_value("issue", issue, 3'b100);
        check_value("branch_use_signed", branch_use_signed, exp_signed);
        check_value("branch_jal", branch_jal, exp_jal);
        check_value("branch_jalr", branch_jalr, exp_jalr);
        release_bus();
    endtask

    task automatic branch_flag_decode();
        expect_branch(enc_s(12'h010, 5'd2, 5'd1, 3'b110, OP_BRANCH), 1'b0, 1'b0, 1'b0); // BLTU
        expect_branch(enc_s(12'h010, 5'd2, 5'd1, 3'b111, OP_BRANCH), 1'b0, 1'b0, 1'b0); // BGEU
        expect_branch(enc_s(12'h010, 5'd2, 5'd1, 3'b100, OP_BRANCH), 1'b1, 1'b0, 1'b0); // BLT
        expect_branch({20'h00100, 5'd1, OP_JAL}, 1'b1, 1'b1, 1'b0);
        expect_branch(enc_i(12'h004, 5'd1, 3'b000, 5'd1, OP_JALR), 1'b1, 1'b0, 1'b1);
    endtask

    //----------------------------------------------------------------------
    // Sequence and watchdog
    //----------------------------------------------------------------------
    initial begin
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instruction  = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        flush        = 1'b0;
        {branch_ready, ls_ready, alu_ready} = 3'b111;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("new_request", {branch_new_request, ls_new_request, alu_new_request}, 3'b000);
        route_opcodes();
        reject_illegal();
        stall_on_hazards();
        alu_operand_rules();
        load_store_forwarding();
        branch_flag_decode();
        $display("%0d checks, %0d errors, %0d assertion failures", check_count, error_count,
                 UUT.issue_ctrl.issue_checks.fail_count);
        if (error_count == 0 && UUT.issue_ctrl.issue_checks.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired before the directed tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

// File: tests/decode_issue_checker.sv
`timescale 1ns/1ps

module decode_issue_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input decode_pkg::unit_sel_t issue,
    input logic                  advance,
    input logic                  alu_new_request,
    input logic                  ls_new_request,
    input logic                  branch_new_request
);

    int fail_count = 0; // Failed assertions so far

    // At most one unit per cycle
    issue_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(issue))
        else begin
            fail_count++;
            $error("issue vector has more than one unit selected");
        end

    no_advance_on_flush: assert property (@(posedge clk) flush |-> !advance)
        else begin
            fail_count++;
            $error("instruction advanced while flush was high");
        end

    requests_clear_after_reset: assert property (@(posedge clk)
        rst |=> !(alu_new_request || ls_new_request || branch_new_request))
        else begin
            fail_count++;
            $error("a new_request strobe is high after reset");
        end

endmodule

bind issue_control decode_issue_checker issue_checks (
    .clk, .rst, .flush, .issue, .advance,
    .alu_new_request, .ls_new_request, .branch_new_request
);

// File: src/decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
    input  logic                      clk,
    input  logic                      rst,
    // Fetch buffer
    input  logic                      instr_valid,
    input  decode_pkg::word_t         instruction,
    input  decode_pkg::word_t         pc,
    output logic                      instr_pop,
    output logic                      illegal_instruction,
    // Register file and scoreboard
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::word_t         rs2_data,
    input  logic                      rs1_conflict,
    input  logic                      rs2_conflict,
    output decode_pkg::reg_addr_t     rs1_addr,
    output decode_pkg::reg_addr_t     rs2_addr,
    output decode_pkg::reg_addr_t     rd_addr,
    output logic                      rd_issued,
    // Units
    input  logic                      alu_ready,
    input  logic                      ls_ready,
    input  logic                      branch_ready,
    input  logic                      flush,
    output decode_pkg::unit_sel_t     issue,
    output logic                      alu_new_request,
    output logic                      ls_new_request,
    output logic                      branch_new_request,
    // ALU operands, registered
    output decode_pkg::operand_t      alu_in1,
    output decode_pkg::operand_t      alu_in2,
    output decode_pkg::word_t         alu_shifter_in,
    output logic                      alu_subtract,
    output logic                      alu_arith,
    output logic                      alu_lshift,
    output decode_pkg::alu_logic_op_t alu_logic_op,
    output decode_pkg::alu_op_t       alu_op,
    // Load/store and branch operands
    output decode_pkg::word_t         ls_offset,
    output logic                      ls_forward,
    output logic                      ls_is_load,
    output logic                      ls_is_store,
    output logic                      branch_use_signed,
    output logic                      branch_jal,
    output logic                      branch_jalr
);
    import decode_pkg::*;

    fn3_t         fn3;
    opcode_trim_t opcode_trim;
    logic         uses_rs1;
    logic         uses_rs2;
    logic         uses_rd;
    unit_sel_t    unit_request;

    instr_classifier classifier (
        .instruction, .rs1_addr, .rs2_addr, .rd_addr, .fn3, .opcode_trim,
        .uses_rs1, .uses_rs2, .uses_rd, .unit_request, .illegal_instruction
    );

    issue_control issue_ctrl (
        .clk, .rst, .instr_valid, .flush, .unit_request,
        .alu_ready, .ls_ready, .branch_ready,
        .uses_rs1, .uses_rs2, .uses_rd, .rs1_conflict, .rs2_conflict,
        .rs2_addr, .rd_addr, .is_load(ls_is_load), .is_store(ls_is_store),
        .issue, .advance(instr_pop), .rd_issued, .ls_forward,
        .alu_new_request, .ls_new_request, .branch_new_request
    );

    alu_operand_prep alu_prep (
        .clk, .alu_issue(issue[ALU_UNIT]), .instruction, .pc, .opcode_trim, .fn3,
        .rs1_data, .rs2_data, .alu_in1, .alu_in2, .alu_shifter_in,
        .alu_subtract, .alu_arith, .alu_lshift, .alu_logic_op, .alu_op
    );

    ls_branch_operand_prep ls_branch_prep (
        .instruction, .opcode_trim, .fn3, .ls_offset,
        .is_load(ls_is_load), .is_store(ls_is_store),
        .branch_use_signed, .branch_jal, .branch_jalr
    );

endmodule

// File: src/ls_branch_operand_prep.sv
`timescale 1ns/1ps

module ls_branch_operand_prep (
    input  decode_pkg::word_t        instruction,
    input  decode_pkg::opcode_trim_t opcode_trim,
    input  decode_pkg::fn3_t         fn3,
    output decode_pkg::word_t        ls_offset,
    output logic                     is_load,
    output logic                     is_store,
    output logic                     branch_use_signed,
    output logic                     branch_jal,
    output logic                     branch_jalr
);
    import decode_pkg::*;

    logic [11:0] imm12;

    //----------------------------------------------------------------------
    // Load/store
    //----------------------------------------------------------------------
    assign is_load  = (opcode_trim == LOAD_T);
    assign is_store = (opcode_trim == STORE_T);

    // S-type splits the immediate around rd
    assign imm12 = is_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];

    assign ls_offset = {{(XLEN-12){imm12[11]}}, imm12};

    //----------------------------------------------------------------------
    // Branch
    //----------------------------------------------------------------------
    assign branch_use_signed = !(fn3 inside {BLTU_FN3, BGEU_FN3});
    assign branch_jal        = (opcode_trim == JAL_T);
    assign branch_jalr       = (opcode_trim == JALR_T);

endmodule

// File: src/alu_operand_prep.sv
`timescale 1ns/1ps

module alu_operand_prep (
    input  logic                      clk,
    input  logic                      alu_issue,
    input  decode_pkg::word_t         instruction,
    input  decode_pkg::word_t         pc,
    input  decode_pkg::opcode_trim_t  opcode_trim,
    input  decode_pkg::fn3_t          fn3,
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::word_t         rs2_data,
    output decode_pkg::operand_t      alu_in1,
    output decode_pkg::operand_t      alu_in2,
    output decode_pkg::word_t         alu_shifter_in,
    output logic                      alu_subtract,
    output logic                      alu_arith,
    output logic                      alu_lshift,
    output decode_pkg::alu_logic_op_t alu_logic_op,
    output decode_pkg::alu_op_t       alu_op
);
    import decode_pkg::*;

    word_t         in1_sel;
    word_t         in2_sel;
    word_t         left_shift_in;
    logic          upper_op; // LUI or AUIPC
    logic          sign_ext;
    logic          sub_sel;
    alu_logic_op_t logic_sel;
    alu_op_t       op_sel;

    assign upper_op = opcode_trim inside {LUI_T, AUIPC_T};
    assign sign_ext = ~fn3[0]; // Unsigned compare for SLTU

    //----------------------------------------------------------------------
    // Operand selection
    //----------------------------------------------------------------------
    always_comb begin
        case (opcode_trim)
            LUI_T:   in1_sel = '0;
            AUIPC_T: in1_sel = pc;
            default: in1_sel = rs1_data;
        endcase
        if (upper_op) begin
            in2_sel = {instruction[31:12], 12'b0};
        end else if (opcode_trim == ARITH_IMM_T) begin
            in2_sel = {{(XLEN-12){instruction[31]}}, instruction[31:20]};
        end else begin
            in2_sel = rs2_data;
        end
    end

    // Left shifts run through the right shifter reversed
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            left_shift_in[i] = rs1_data[XLEN-1-i];
        end
    end

    // Select decode, upper immediates go through the adder
    always_comb begin
        logic_sel = ALU_LOGIC_ADD;
        op_sel    = ALU_ADD_SUB;
        if (!upper_op) begin
            case (fn3)
                XOR_FN3:           logic_sel = ALU_LOGIC_XOR;
                OR_FN3:            logic_sel = ALU_LOGIC_OR;
                AND_FN3:           logic_sel = ALU_LOGIC_AND;
                SLT_FN3, SLTU_FN3: op_sel = ALU_SLT;
                SLL_FN3:           op_sel = ALU_LSHIFT;
                SRA_FN3:           op_sel = ALU_RSHIFT;
                default:           op_sel = ALU_ADD_SUB;
            endcase
        end
    end

    assign sub_sel = ~upper_op & ((fn3 inside {SLT_FN3, SLTU_FN3}) ||
                     ((fn3 == ADD_SUB_FN3) && instruction[30] && (opcode_trim == ARITH_T)));

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_in1        <= {in1_sel[XLEN-1] & sign_ext, in1_sel};
            alu_in2        <= {in2_sel[XLEN-1] & sign_ext, in2_sel};
            alu_shifter_in <= fn3[2] ? rs1_data : left_shift_in;
            alu_subtract   <= sub_sel;
            alu_arith      <= in1_sel[XLEN-1] & instruction[30]; // Shift-in bit
            alu_lshift     <= ~fn3[2];
            alu_logic_op   <= logic_sel;
            alu_op         <= op_sel;
        end
    end

endmodule

// File: src/issue_control.sv
`timescale 1ns/1ps

module issue_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic                  flush,
    input  decode_pkg::unit_sel_t unit_request,
    input  logic                  alu_ready,
    input  logic                  ls_ready,
    input  logic                  branch_ready,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  logic                  uses_rd,
    input  logic                  rs1_conflict,
    input  logic                  rs2_conflict,
    input  decode_pkg::reg_addr_t rs2_addr,
    input  decode_pkg::reg_addr_t rd_addr,
    input  logic                  is_load,
    input  logic                  is_store,
    output decode_pkg::unit_sel_t issue,
    output logic                  advance,
    output logic                  rd_issued,
    output logic                  ls_forward,
    output logic                  alu_new_request,
    output logic                  ls_new_request,
    output logic                  branch_new_request
);
    import decode_pkg::*;

    unit_sel_t unit_ready;
    logic      issue_valid;
    logic      rs1_stall;
    logic      rs2_stall;
    logic      forward_ok;
    logic      last_was_load;
    reg_addr_t load_rd;

    //----------------------------------------------------------------------
    // Issue gating
    //----------------------------------------------------------------------
    assign unit_ready[ALU_UNIT]    = alu_ready;
    assign unit_ready[LS_UNIT]     = ls_ready;
    assign unit_ready[BRANCH_UNIT] = branch_ready;

    assign issue_valid = instr_valid & ~flush;

    // Store data can be forwarded from the load just issued
    assign forward_ok = is_store & last_was_load & (rs2_addr == load_rd);

    assign rs1_stall = uses_rs1 & rs1_conflict;
    assign rs2_stall = uses_rs2 & rs2_conflict & ~forward_ok;

    // Illegal instructions request no unit, so they never issue
    assign issue   = (issue_valid & ~rs1_stall & ~rs2_stall) ? (unit_request & unit_ready) : '0;
    assign advance = |issue;

    assign rd_issued  = advance & uses_rd & (rd_addr != '0);
    assign ls_forward = is_store & rs2_conflict;

    //----------------------------------------------------------------------
    // Store-after-load tracker
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (issue[LS_UNIT]) begin
            load_rd <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_was_load <= 1'b0;
        end else if (advance) begin
            if (issue[LS_UNIT]) begin
                last_was_load <= is_load; // A store ends the window
            end else if (uses_rd && (rd_addr == load_rd)) begin
                last_was_load <= 1'b0;    // Load result overwritten
            end
        end
    end

    // Unit request strobes, one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_new_request    <= 1'b0;
            ls_new_request     <= 1'b0;
            branch_new_request <= 1'b0;
        end else begin
            alu_new_request    <= issue[ALU_UNIT];
            ls_new_request     <= issue[LS_UNIT];
            branch_new_request <= issue[BRANCH_UNIT];
        end
    end

endmodule

// File: src/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
    input  decode_pkg::word_t        instruction,
    output decode_pkg::reg_addr_t    rs1_addr,
    output decode_pkg::reg_addr_t    rs2_addr,
    output decode_pkg::reg_addr_t    rd_addr,
    output decode_pkg::fn3_t         fn3,
    output decode_pkg::opcode_trim_t opcode_trim,
    output logic                     uses_rs1,
    output logic                     uses_rs2,
    output logic                     uses_rd,
    output decode_pkg::unit_sel_t    unit_request,
    output logic                     illegal_instruction
);
    import decode_pkg::*;

    logic opcode_ok; // 32-bit encoding marker
    logic mul_div_op;

    //----------------------------------------------------------------------
    // Fields
    //----------------------------------------------------------------------
    assign rs1_addr    = instruction[19:15];
    assign rs2_addr    = instruction[24:20];
    assign rd_addr     = instruction[11:7];
    assign fn3         = instruction[14:12];
    assign opcode_trim = instruction[6:2];

    assign opcode_ok  = (instruction[1:0] == 2'b11);
    assign mul_div_op = instruction[25]; // M extension, not supported

    // Register usage by format
    always_comb begin
        uses_rs1 = !(opcode_trim inside {LUI_T, AUIPC_T, JAL_T});
        uses_rs2 = opcode_trim inside {BRANCH_T, STORE_T, ARITH_T};
        uses_rd  = !(opcode_trim inside {BRANCH_T, STORE_T});
    end

    //----------------------------------------------------------------------
    // Unit request
    //----------------------------------------------------------------------
    always_comb begin
        unit_request = '0;
        if (opcode_ok) begin
            case (opcode_trim)
                LUI_T, AUIPC_T, ARITH_IMM_T: begin
                    unit_request[ALU_UNIT] = 1'b1;
                end
                ARITH_T: begin
                    unit_request[ALU_UNIT] = ~mul_div_op;
                end
                LOAD_T, STORE_T: begin
                    unit_request[LS_UNIT] = 1'b1;
                end
                BRANCH_T, JAL_T, JALR_T: begin
                    unit_request[BRANCH_UNIT] = 1'b1;
                end
                default: begin
                    unit_request = '0; // SYSTEM, FENCE, AMO and unknown
                end
            endcase
        end
    end

    // Anything without a unit is illegal
    assign illegal_instruction = (unit_request == '0);

endmodule

// File: src/decode_pkg.sv
package decode_pkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;    // Data, PC or instruction word
    typedef logic [XLEN:0]   operand_t; // Sign-extension bit on top
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      fn3_t;
    typedef logic [4:0]      opcode_trim_t; // Instruction bits 6:2

    //----------------------------------------------------------------------
    // Opcodes, bits 6 to 2
    //----------------------------------------------------------------------
    localparam opcode_trim_t LUI_T       = 5'b01101;
    localparam opcode_trim_t AUIPC_T     = 5'b00101;
    localparam opcode_trim_t JAL_T       = 5'b11011;
    localparam opcode_trim_t JALR_T      = 5'b11001;
    localparam opcode_trim_t BRANCH_T    = 5'b11000;
    localparam opcode_trim_t LOAD_T      = 5'b00000;
    localparam opcode_trim_t STORE_T     = 5'b01000;
    localparam opcode_trim_t ARITH_IMM_T = 5'b00100;
    localparam opcode_trim_t ARITH_T     = 5'b01100;

    //----------------------------------------------------------------------
    // Function codes
    //----------------------------------------------------------------------
    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3     = 3'b001;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    localparam fn3_t XOR_FN3     = 3'b100;
    localparam fn3_t SRA_FN3     = 3'b101; // Also SRL, bit 30 picks
    localparam fn3_t OR_FN3      = 3'b110;
    localparam fn3_t AND_FN3     = 3'b111;

    localparam fn3_t BLTU_FN3    = 3'b110;
    localparam fn3_t BGEU_FN3    = 3'b111;

    // ALU result path select
    typedef enum logic [1:0] {
        ALU_ADD_SUB = 2'b00,
        ALU_SLT     = 2'b01,
        ALU_LSHIFT  = 2'b10,
        ALU_RSHIFT  = 2'b11
    } alu_op_t;

    // Logic unit select, add passes the adder through
    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

    //----------------------------------------------------------------------
    // Execution units
    //----------------------------------------------------------------------
    typedef logic [2:0] unit_sel_t; // One-hot

    localparam int ALU_UNIT    = 0;
    localparam int LS_UNIT     = 1;
    localparam int BRANCH_UNIT = 2;

endpackage
